// File: list.f
+incdir+common
common/nabp_pkg.sv
common/swap_if.sv
swap_control/swap_control.sv
swap_control/swappable.sv
hw/line_accum.sv
hw/nabp_swap_top.sv
bench/tb_swap.sv

// File: Makefile
# Verilator build of the swap front end testbench

TOP = tb_swap

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

# $fatal in the testbench gives a failing exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: bench/tb_swap.sv
`include "nabp_consts.svh"

module tb_swap
    import nabp_pkg::*;
();

    localparam int NUM_DIRECTED = 6;
    localparam int NUM_RANDOM = 20;
    localparam int TIMEOUT_CYCLES = 200 * (NUM_DIRECTED + NUM_RANDOM) + 100;
    localparam int LINES_SPAN = `kPartitionSize * `kLineSize;

    logic       clk = 1'b0;
    logic       reset_n;
    angle_t     hs_angle;
    logic       hs_next_angle_ack;
    logic       hs_next_angle;
    sample_t    fr0_val = '0;
    sample_t    fr1_val = '0;
    s_addr_t    fr0_s_val;
    s_addr_t    fr1_s_val;
    scan_mode_t pe_scan_mode;
    sum_t       line_sum;
    line_idx_t  line_idx;
    logic       line_valid;

    angle_t directed_angles [NUM_DIRECTED] = '{8'd0, 8'd31, 8'd32, 8'd95, 8'd96, 8'd200};

    // expected lines in order with one entry per line
    sum_t       exp_sum_q [$];
    line_idx_t  exp_idx_q [$];
    scan_mode_t exp_mode_q [$];
    int         lines_checked = 0;

    angle_t     cur_angle = '0;
    logic [7:0] lfsr;
    int         cycle_count = 0;

    // fill tracking owned by the address monitor
    s_addr_t ram_addr0 = '0;
    s_addr_t ram_addr1 = '0;
    s_addr_t prev_addr0 = '0;
    s_addr_t prev_addr1 = '0;
    int      fill_count = 0;
    logic    angle_active = 1'b0;

    nabp_swap_top dut_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_next_angle     (hs_next_angle),
        .fr0_val           (fr0_val),
        .fr1_val           (fr1_val),
        .fr0_s_val         (fr0_s_val),
        .fr1_s_val         (fr1_s_val),
        .pe_scan_mode      (pe_scan_mode),
        .line_sum          (line_sum),
        .line_idx          (line_idx),
        .line_valid        (line_valid)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            fail_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    // filtered RAM contents
    function automatic sample_t ram_data(input s_addr_t addr);
        int value;
        value = int'(addr) * 3 - 500;
        return sample_t'(value);
    endfunction

    // sum of one line with address = angle + line * length + sample
    function automatic sum_t expected_sum(input angle_t angle, input int line);
        sum_t    acc;
        s_addr_t addr;
        acc = '0;
        for (int s = 0; s < `kLineSize; s++)
        begin
            addr = s_addr_t'(int'(angle) + line * `kLineSize + s);
            acc = acc + sum_t'(ram_data(addr));
        end
        return acc;
    endfunction

    function automatic scan_mode_t expected_mode(input angle_t angle);
        if (int'(angle) < `kAngle45 || int'(angle) >= `kAngle135)
            return scan_x;
        return scan_y;
    endfunction

    // taps 8, 6, 5, 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    task automatic random_angle(output angle_t angle);
        angle = '0;
        for (int b = 0; b < `kAngleLength; b++)
        begin
            lfsr = lfsr_step(lfsr);
            angle = {angle[`kAngleLength-2:0], lfsr[0]};
        end
    endtask

    task automatic offer_angle(input angle_t angle);
        while (!hs_next_angle)
        begin
            @(posedge clk);
            #1;
        end
        hs_angle = angle;
        hs_next_angle_ack = 1'b1;
        cur_angle = angle;
        for (int line = 0; line < `kPartitionSize; line++)
        begin
            exp_sum_q.push_back(expected_sum(angle, line));
            exp_idx_q.push_back(line_idx_t'(line));
            exp_mode_q.push_back(expected_mode(angle));
        end
        @(posedge clk);
        #1;
        hs_next_angle_ack = 1'b0;
    endtask

    task automatic wait_angle_done();
        @(posedge clk);
        #1;
        while (!hs_next_angle)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // address range and fill order on one RAM port
    task automatic check_port(input int port, input s_addr_t addr, input s_addr_t prev);
        s_addr_t offset;
        int      line;
        offset = addr - s_addr_t'(cur_angle);
        if (int'(offset) >= LINES_SPAN)
            fail_run($sformatf("Fail fr%0d_s_val: 0x%0h, offset 0x%0h from angle 0x%0h",
                               port, addr, offset, cur_angle));
        // second address of a line marks a fill in progress
        if (int'(offset) % `kLineSize == 1 && addr == prev + s_addr_t'(1))
        begin
            line = int'(offset) / `kLineSize;
            check_value("fill port", 32'(port), 32'(fill_count % 2));
            check_value("fill line", 32'(line), 32'(fill_count));
            fill_count++;
        end
    endtask

    // synchronous RAM with data one cycle after the address
    always @(negedge clk)
    begin
        ram_addr0 = fr0_s_val;
        ram_addr1 = fr1_s_val;
    end

    always @(posedge clk)
    begin
        #1;
        fr0_val = ram_data(ram_addr0);
        fr1_val = ram_data(ram_addr1);
    end

    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (hs_next_angle)
            begin
                if (angle_active)
                    check_value("fills per angle", 32'(fill_count), 32'(`kPartitionSize));
                angle_active = 1'b0;
                fill_count = 0;
            end
            else
            begin
                angle_active = 1'b1;
                check_port(0, fr0_s_val, prev_addr0);
                check_port(1, fr1_s_val, prev_addr1);
            end
            prev_addr0 = fr0_s_val;
            prev_addr1 = fr1_s_val;
        end
    end

    // compare each emitted line with the next expected one
    always @(negedge clk)
    begin
        if (reset_n && line_valid)
        begin
            if (lines_checked >= exp_sum_q.size())
                fail_run("line_valid was raised while no line was outstanding");
            else
            begin
                check_value("line_sum", 32'(line_sum), 32'(exp_sum_q[lines_checked]));
                check_value("line_idx", 32'(line_idx), 32'(exp_idx_q[lines_checked]));
                check_value("pe_scan_mode", 32'(pe_scan_mode), 32'(exp_mode_q[lines_checked]));
                lines_checked++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            fail_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    initial
    begin
        angle_t angle;
        reset_n = 1'b0;
        hs_angle = '0;
        hs_next_angle_ack = 1'b0;
        lfsr = 8'd83;
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // idle while waiting for the host
        repeat (10)
        begin
            @(posedge clk);
            #1;
            check_value("hs_next_angle", 32'(hs_next_angle), 32'd1);
        end

        // threshold angles one at a time
        for (int i = 0; i < NUM_DIRECTED; i++)
        begin
            offer_angle(directed_angles[i]);
            wait_angle_done();
            check_value("lines per angle", 32'(lines_checked), 32'(exp_sum_q.size()));
        end

        // random angles back to back
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            random_angle(angle);
            offer_angle(angle);
        end
        wait_angle_done();
        repeat (2) @(posedge clk);

        if (lines_checked == exp_sum_q.size())
        begin
            $display("STATUS: PASS");
            $finish;
        end
        else
            fail_run($sformatf("only %0d of %0d lines arrived", lines_checked, exp_sum_q.size()));
    end

endmodule

// File: hw/nabp_swap_top.sv
module nabp_swap_top
    import nabp_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    // host
    input  angle_t     hs_angle,
    input  logic       hs_next_angle_ack,
    output logic       hs_next_angle,
    // filtered RAM, one port per buffer
    input  sample_t    fr0_val,
    input  sample_t    fr1_val,
    output s_addr_t    fr0_s_val,
    output s_addr_t    fr1_s_val,
    // processing element results
    output scan_mode_t pe_scan_mode,
    output sum_t       line_sum,
    output line_idx_t  line_idx,
    output logic       line_valid
);

    logic pe_reset;
    logic pe_kick;
    logic pe_sel;

    swap_if sw0_if ();
    swap_if sw1_if ();

    swap_control ctrl_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_next_angle     (hs_next_angle),
        .pe_reset          (pe_reset),
        .pe_kick           (pe_kick),
        .pe_scan_mode      (pe_scan_mode),
        .pe_sel            (pe_sel),
        .sw0               (sw0_if.controller),
        .sw1               (sw1_if.controller)
    );

    swappable sw0_i
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .fr_val   (fr0_val),
        .fr_s_val (fr0_s_val),
        .sw       (sw0_if.buffer)
    );

    swappable sw1_i
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .fr_val   (fr1_val),
        .fr_s_val (fr1_s_val),
        .sw       (sw1_if.buffer)
    );

    // simplified processing element, one sum per line
    line_accum accum_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .pe_reset   (pe_reset),
        .pe_kick    (pe_kick),
        .pe_sel     (pe_sel),
        .tap0       (sw0_if.tap),
        .tap1       (sw1_if.tap),
        .en0        (sw0_if.pe_en),
        .en1        (sw1_if.pe_en),
        .line_sum   (line_sum),
        .line_idx   (line_idx),
        .line_valid (line_valid)
    );

endmodule

// File: hw/line_accum.sv
module line_accum
    import nabp_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      pe_reset,
    input  logic      pe_kick,
    input  logic      pe_sel,
    // taps and enables of both buffers
    input  sample_t   tap0,
    input  sample_t   tap1,
    input  logic      en0,
    input  logic      en1,
    output sum_t      line_sum,
    output line_idx_t line_idx,
    output logic      line_valid
);

    logic      cur_sel;
    logic      en;
    logic      en_d;
    sample_t   tap;
    sum_t      acc;
    line_idx_t idx_q;

    assign en = cur_sel ? en1 : en0;
    assign tap = cur_sel ? tap1 : tap0;

    // falling enable marks the end of a line
    assign line_valid = en_d & ~en;
    assign line_sum = acc;
    assign line_idx = idx_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cur_sel <= 1'b0;
            en_d <= 1'b0;
            acc <= '0;
            idx_q <= '0;
        end
        else
        begin
            en_d <= en;
            // buffer that begins shifting next cycle
            if (pe_kick)
                cur_sel <= pe_sel;
            if (pe_reset)
            begin
                idx_q <= '0;
                acc <= '0;
            end
            else if (line_valid)
            begin
                idx_q <= idx_q + line_idx_t'(1);
                acc <= '0;
            end
            else if (en)
                acc <= acc + sum_t'(tap);
        end
    end

endmodule

// File: swap_control/swappable.sv
`include "nabp_consts.svh"

module swappable
    import nabp_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    // filtered RAM port with data one cycle after the address
    input  sample_t fr_val,
    output s_addr_t fr_s_val,
    swap_if.buffer  sw
);

    localparam int POS_W = $clog2(`kLineSize);

    typedef logic [POS_W-1:0] pos_t;
    typedef logic [POS_W:0] req_cnt_t;

    localparam pos_t POS_LAST = pos_t'(`kLineSize - 1);
    localparam req_cnt_t REQ_LAST = req_cnt_t'(`kLineSize - 1);
    localparam req_cnt_t REQ_ALL = req_cnt_t'(`kLineSize);

    typedef enum logic [1:0]
    {
        buf_empty,
        buf_fill,
        buf_full,
        buf_shift
    } buf_state_t;

    buf_state_t state;
    sample_t    line_q [`kLineSize];
    s_addr_t    addr_q;
    req_cnt_t   issued;
    pos_t       wr_pos;
    pos_t       rd_pos;

    // first address goes out in the fill_start cycle itself
    assign fr_s_val = (state == buf_empty) ? sw.fill_base : addr_q;

    assign sw.swap = (state == buf_full);
    assign sw.next_itr = (state == buf_empty);
    assign sw.pe_en = (state == buf_shift);
    assign sw.tap = line_q[rd_pos];

    // one returned sample lands in every fill cycle
    always_ff @(posedge clk)
    begin
        if (state == buf_fill)
            line_q[wr_pos] <= fr_val;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= buf_empty;
            issued <= '0;
            wr_pos <= '0;
            rd_pos <= '0;
        end
        else
        begin
            case (state)
                // the next_itr handshake ends the empty phase
                buf_empty:
                    if (sw.next_itr_ack)
                    begin
                        state <= buf_fill;
                        issued <= req_cnt_t'(1);
                        wr_pos <= '0;
                    end
                buf_fill:
                begin
                    if (issued != REQ_ALL)
                        issued <= issued + req_cnt_t'(1);
                    wr_pos <= wr_pos + pos_t'(1);
                    if (wr_pos == POS_LAST)
                        state <= buf_full;
                end
                buf_full:
                    if (sw.swap_ack)
                    begin
                        state <= buf_shift;
                        rd_pos <= '0;
                    end
                buf_shift:
                begin
                    rd_pos <= rd_pos + pos_t'(1);
                    if (rd_pos == POS_LAST)
                        state <= buf_empty;
                end
                default:
                    state <= buf_empty;
            endcase
        end
    end

    // address walk that parks on the last sample of the line
    always_ff @(posedge clk)
    begin
        if (state == buf_empty && sw.fill_start)
            addr_q <= sw.fill_base + s_addr_t'(1);
        else if (state == buf_fill && issued < REQ_LAST)
            addr_q <= addr_q + s_addr_t'(1);
    end

endmodule

// File: swap_control/swap_control.sv
`include "nabp_consts.svh"

module swap_control
    import nabp_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    // host side
    input  angle_t     hs_angle,
    input  logic       hs_next_angle_ack,
    output logic       hs_next_angle,
    // processing element control
    output logic       pe_reset,
    output logic       pe_kick,
    output scan_mode_t pe_scan_mode,
    output logic       pe_sel,
    // the two line buffers
    swap_if.controller sw0,
    swap_if.controller sw1
);

    localparam line_idx_t LAST_LINE = line_idx_t'(`kPartitionSize - 1);
    localparam s_addr_t LINE_STRIDE = s_addr_t'(`kLineSize);
    localparam angle_t ANGLE_45 = angle_t'(`kAngle45);
    localparam angle_t ANGLE_135 = angle_t'(`kAngle135);

    ctrl_state_t state;
    ctrl_state_t next_state;
    angle_t      angle_q;
    line_idx_t   line_itr;
    line_idx_t   fill_idx;
    s_addr_t     fill_base;

    // sw_sel picks the buffer being filled (swa), the other one (swb) shifts
    logic sw_sel;
    logic swa_swap;
    logic swa_next_itr;
    logic swb_next_itr;
    logic swap_ack;
    logic has_next_itr;
    logic swa_next_itr_ack;
    logic swb_next_itr_ack;
    logic sw0_next_itr_ack;
    logic sw1_next_itr_ack;

    assign swa_swap = sw_sel ? sw1.swap : sw0.swap;
    assign swa_next_itr = sw_sel ? sw1.next_itr : sw0.next_itr;
    assign swb_next_itr = sw_sel ? sw0.next_itr : sw1.next_itr;

    // a full buffer waits until the other one has drained
    assign swap_ack = (state == fill || state == fill_and_shift) &&
                      swa_swap && swb_next_itr;
    assign has_next_itr = (line_itr != LAST_LINE);

    // first line starts in setup, the rest start on each swap
    assign swa_next_itr_ack = (state == setup) && swa_next_itr;
    assign swb_next_itr_ack = has_next_itr && swap_ack;
    assign sw0_next_itr_ack = sw_sel ? swb_next_itr_ack : swa_next_itr_ack;
    assign sw1_next_itr_ack = sw_sel ? swa_next_itr_ack : swb_next_itr_ack;

    // base address of the line about to be filled
    assign fill_idx = (state == setup) ? line_itr : line_itr + line_idx_t'(1);
    assign fill_base = s_addr_t'(angle_q) + s_addr_t'(fill_idx) * LINE_STRIDE;

    assign sw0.fill_start = sw0_next_itr_ack;
    assign sw0.next_itr_ack = sw0_next_itr_ack;
    assign sw0.fill_base = fill_base;
    assign sw0.swap_ack = ~sw_sel & swap_ack;

    assign sw1.fill_start = sw1_next_itr_ack;
    assign sw1.next_itr_ack = sw1_next_itr_ack;
    assign sw1.fill_base = fill_base;
    assign sw1.swap_ack = sw_sel & swap_ack;

    assign hs_next_angle = (state == ready);
    assign pe_reset = (state == ready) && hs_next_angle_ack;
    assign pe_kick = swap_ack;
    // still the old select during the kick, i.e. the buffer starting to shift
    assign pe_sel = sw_sel;

    always_comb
    begin
        next_state = state;
        case (state)
            ready:
                if (hs_next_angle_ack)
                    next_state = setup;
            setup:
                if (swa_next_itr)
                    next_state = fill;
            fill, fill_and_shift:
                if (swap_ack)
                    next_state = has_next_itr ? fill_and_shift : shift;
            shift:
                if (swb_next_itr)
                    next_state = ready;
            default:
                next_state = ready;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready;
            sw_sel <= 1'b0;
            line_itr <= '0;
            angle_q <= '0;
            pe_scan_mode <= scan_x;
        end
        else
        begin
            state <= next_state;
            if (swap_ack)
            begin
                sw_sel <= ~sw_sel;
                line_itr <= line_itr + line_idx_t'(1);
            end
            // new angle accepted
            if (pe_reset)
            begin
                angle_q <= hs_angle;
                line_itr <= '0;
                if (hs_angle < ANGLE_45 || hs_angle >= ANGLE_135)
                    pe_scan_mode <= scan_x;
                else
                    pe_scan_mode <= scan_y;
            end
        end
    end

endmodule

// File: common/swap_if.sv
interface swap_if
    import nabp_pkg::*;
();

    // controller to buffer
    logic    fill_start;
    s_addr_t fill_base;
    logic    swap_ack;
    logic    next_itr_ack;

    // buffer to controller
    logic    swap;
    logic    next_itr;

    // buffer to processing element
    logic    pe_en;
    sample_t tap;

    modport controller
    (
        output fill_start,
        output fill_base,
        output swap_ack,
        output next_itr_ack,
        input  swap,
        input  next_itr
    );

    modport buffer
    (
        input  fill_start,
        input  fill_base,
        input  swap_ack,
        input  next_itr_ack,
        output swap,
        output next_itr,
        output pe_en,
        output tap
    );

endinterface

// File: common/nabp_pkg.sv
`include "nabp_consts.svh"

package nabp_pkg;

    typedef logic [`kAngleLength-1:0] angle_t;

    typedef logic signed [`kFilteredDataLength-1:0] sample_t;

    typedef logic [`kSLength-1:0] s_addr_t;

    // line number inside the current partition
    typedef logic [`kPartitionSizeLength-1:0] line_idx_t;

    typedef logic signed [`kLineSumLength-1:0] sum_t;

    // swap controller states
    typedef enum logic [2:0]
    {
        ready,
        setup,
        fill,
        fill_and_shift,
        shift
    } ctrl_state_t;

    // x for shallow angles, y for steep ones
    typedef enum logic
    {
        scan_x,
        scan_y
    } scan_mode_t;

endpackage

// File: common/nabp_consts.svh
`ifndef NABP_CONSTS_SVH
`define NABP_CONSTS_SVH

// samples per detector line
`define kLineSize 8

// lines handled per angle
`define kPartitionSize 4
`define kPartitionSizeLength 2

// projection angle in angle units
`define kAngleLength 8

// scan mode thresholds
`define kAngle45 32
`define kAngle135 96

// filtered sample width, signed
`define kFilteredDataLength 12

// filtered RAM address width
`define kSLength 10

// accumulated line sum width
`define kLineSumLength 16

`endif
